// ==== slot_dma_pkg.sv ====
package slot_dma_pkg;

  // Packet lengths
  localparam int LEN_WIDTH = 16;
  typedef logic [LEN_WIDTH-1:0] pkt_len_t;

  // MAC side
  localparam int PORT_COUNT = 2;
  localparam int PEND_WIDTH = 10;

  // Receive address layout
  localparam int SLOT_LEAD_ZERO = 8;
  localparam logic [7:0] RX_WRITE_OFFSET = 8'h0A;

  // Value loaded into the max length register by reset
  localparam pkt_len_t DEFAULT_MAX_PKT_LEN = 16'd1024;

  // Core message, listed high to low
  typedef struct packed {
    logic [15:0] reserved;
    logic [15:0] slot_offset;
    logic [7:0]  slot_no;
    logic [7:0]  out_port;
    pkt_len_t    pkt_len;
  } core_msg_t;

endpackage

// ==== slot_queue.sv ====
module slot_queue #(
  parameter int CORE_COUNT = 16,
  parameter int SLOT_COUNT = 16
) (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic                                                  recycle_valid,
  input  logic [$clog2(CORE_COUNT)+$clog2(SLOT_COUNT)-1:0]      recycle_desc,
  input  logic                                                  inject_valid,
  input  logic [$clog2(CORE_COUNT)+$clog2(SLOT_COUNT)-1:0]      inject_desc,
  output logic                                                  inject_ready,
  output logic                                                  head_valid,
  output logic [$clog2(CORE_COUNT)+$clog2(SLOT_COUNT)-1:0]      head_desc,
  input  logic                                                  head_pop
);

  localparam int core_no_width = $clog2(CORE_COUNT);
  localparam int slot_no_width = $clog2(SLOT_COUNT);
  localparam int desc_width    = core_no_width + slot_no_width;
  localparam int depth         = CORE_COUNT * SLOT_COUNT;
  localparam int ptr_width     = $clog2(depth);
  localparam int cnt_width     = $clog2(depth + 1);

  logic [desc_width-1:0] mem [depth];
  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;
  logic [cnt_width-1:0]  count;
  logic                  running;
  logic                  full;
  logic                  wr_en;
  logic                  rd_en;
  logic [desc_width-1:0] wr_desc;

  assign full         = (count == cnt_width'(depth));
  assign inject_ready = running && !recycle_valid && !full;

  // Recycled slots take priority over injected ones
  assign wr_desc = recycle_valid ? recycle_desc : inject_desc;
  assign wr_en   = !full && (recycle_valid || (inject_valid && inject_ready));

  // Refill the head register when it is empty or being taken
  assign rd_en = (count != '0) && (!head_valid || head_pop);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_desc;
    end
    if (rd_en) begin
      head_desc <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      running    <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      head_valid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (wr_en) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (rd_en) begin
        head_valid <= 1'b1;
      end else if (head_pop) begin
        head_valid <= 1'b0;
      end
    end
  end

endmodule

// ==== slot_addr_lookup.sv ====
module slot_addr_lookup import slot_dma_pkg::*; #(
  parameter int CORE_COUNT      = 16,
  parameter int SLOT_COUNT      = 16,
  parameter int CORE_ADDR_WIDTH = 16
) (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic                                                   head_valid,
  input  logic [$clog2(CORE_COUNT)+$clog2(SLOT_COUNT)-1:0]       head_desc,
  output logic                                                   head_pop,
  input  logic                                                   slot_addr_wr_valid,
  input  logic [$clog2(SLOT_COUNT)-1:0]                          slot_addr_wr_no,
  input  logic [CORE_ADDR_WIDTH-1-SLOT_LEAD_ZERO-1:0]            slot_addr_wr_data,
  input  logic                                                   drop_list_valid,
  input  logic [CORE_COUNT-1:0]                                  drop_list,
  output logic                                                   cand_valid,
  output logic [$clog2(CORE_COUNT)-1:0]                          cand_core,
  output logic [$clog2(SLOT_COUNT)-1:0]                          cand_slot,
  output logic [CORE_ADDR_WIDTH+$clog2(CORE_COUNT)-1:0]          cand_addr,
  input  logic                                                   cand_take
);

  localparam int core_no_width = $clog2(CORE_COUNT);
  localparam int slot_no_width = $clog2(SLOT_COUNT);
  localparam int slot_addr_eff = CORE_ADDR_WIDTH - 1 - SLOT_LEAD_ZERO;

  logic [slot_addr_eff-1:0] slot_addr_mem [SLOT_COUNT];
  logic [CORE_COUNT-1:0]    drop_list_r;
  logic [core_no_width-1:0] head_core;
  logic [slot_no_width-1:0] head_slot;
  logic                     load;

  assign head_core = head_desc[core_no_width+slot_no_width-1:slot_no_width];
  assign head_slot = head_desc[slot_no_width-1:0];

  // One descriptor per cycle while the arbiter keeps taking
  assign load     = head_valid && (!cand_valid || cand_take);
  assign head_pop = load;

  always_ff @(posedge clk) begin
    if (slot_addr_wr_valid) begin
      slot_addr_mem[slot_addr_wr_no] <= slot_addr_wr_data;
    end
    if (load) begin
      cand_core <= head_core;
      cand_slot <= head_slot;
      cand_addr <= {head_core, 1'b0, slot_addr_mem[head_slot], RX_WRITE_OFFSET};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_list_r <= '0;
      cand_valid  <= 1'b0;
    end else begin
      if (drop_list_valid) begin
        drop_list_r <= drop_list;
      end
      // Dropped cores never become candidates
      if (load) begin
        cand_valid <= !drop_list_r[head_core];
      end else if (cand_take) begin
        cand_valid <= 1'b0;
      end
    end
  end

endmodule

// ==== rx_port_arbiter.sv ====
module rx_port_arbiter import slot_dma_pkg::*; #(
  parameter int CORE_COUNT      = 16,
  parameter int CORE_ADDR_WIDTH = 16
) (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              cand_valid,
  input  logic [CORE_ADDR_WIDTH+$clog2(CORE_COUNT)-1:0]     cand_addr,
  output logic                                              cand_take,
  input  logic [PORT_COUNT-1:0]                             incoming_pkt_ready,
  input  logic [PORT_COUNT-1:0]                             rx_desc_ready,
  input  pkt_len_t                                          max_pkt_len,
  output logic [PORT_COUNT-1:0]                             rx_desc_valid,
  output logic [CORE_ADDR_WIDTH+$clog2(CORE_COUNT)-1:0]     rx_desc_addr,
  output pkt_len_t                                          rx_desc_len
);

  localparam int core_no_width = $clog2(CORE_COUNT);
  localparam int addr_width    = CORE_ADDR_WIDTH + core_no_width;

  logic [PEND_WIDTH-1:0] pending [PORT_COUNT];
  logic [PORT_COUNT-1:0] can_serve;
  logic                  last_port;
  logic                  sel_port;

  always_comb begin
    for (int p = 0; p < PORT_COUNT; p++) begin
      can_serve[p] = cand_valid && rx_desc_ready[p] &&
                     ((pending[p] != '0) || incoming_pkt_ready[p]);
    end
  end

  // Alternate when both ports qualify
  always_comb begin
    sel_port = last_port;
    if (can_serve[0] && can_serve[1]) begin
      sel_port = !last_port;
    end else if (can_serve[0]) begin
      sel_port = 1'b0;
    end else if (can_serve[1]) begin
      sel_port = 1'b1;
    end
  end

  assign rx_desc_valid[0] = can_serve[0] && !sel_port;
  assign rx_desc_valid[1] = can_serve[1] && sel_port;
  assign cand_take        = |rx_desc_valid;
  assign rx_desc_addr     = cand_addr[addr_width-1:0];
  assign rx_desc_len      = max_pkt_len;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_port <= 1'b1;
      for (int p = 0; p < PORT_COUNT; p++) begin
        pending[p] <= '0;
      end
    end else begin
      if (cand_take) begin
        last_port <= sel_port;
      end
      for (int p = 0; p < PORT_COUNT; p++) begin
        if (incoming_pkt_ready[p] && !rx_desc_valid[p]) begin
          pending[p] <= pending[p] + 1'b1;
        end else if (rx_desc_valid[p] && !incoming_pkt_ready[p]) begin
          pending[p] <= pending[p] - 1'b1;
        end
      end
    end
  end

endmodule

// ==== tx_desc_issuer.sv ====
module tx_desc_issuer import slot_dma_pkg::*; #(
  parameter int CORE_COUNT      = 16,
  parameter int SLOT_COUNT      = 16,
  parameter int CORE_ADDR_WIDTH = 16
) (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              msg_valid,
  input  core_msg_t                                         msg_data,
  input  logic [$clog2(CORE_COUNT)-1:0]                     msg_core_no,
  output logic                                              msg_ready,
  input  logic [PORT_COUNT-1:0]                             tx_desc_ready,
  output logic [PORT_COUNT-1:0]                             tx_desc_valid,
  output logic [CORE_ADDR_WIDTH+$clog2(CORE_COUNT)-1:0]     tx_desc_addr,
  output pkt_len_t                                          tx_desc_len,
  input  logic [PORT_COUNT-1:0]                             pkt_sent_out_valid,
  output logic                                              recycle_valid,
  output logic [$clog2(CORE_COUNT)+$clog2(SLOT_COUNT)-1:0]  recycle_desc
);

  localparam int core_no_width = $clog2(CORE_COUNT);
  localparam int slot_no_width = $clog2(SLOT_COUNT);

  logic                     port;
  logic                     issue;
  logic                     valid_r;
  logic                     hold;
  logic                     port_r;
  logic [core_no_width-1:0] last_core [PORT_COUNT];
  logic [slot_no_width-1:0] last_slot [PORT_COUNT];

  assign port      = msg_data.out_port[0];
  assign msg_ready = tx_desc_ready[port] && !hold;
  // Zero length means the packet is dropped
  assign issue     = msg_valid && msg_ready && (msg_data.pkt_len != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= 1'b0;
      hold    <= 1'b1;
    end else begin
      valid_r <= issue;
      hold    <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      tx_desc_addr    <= {msg_core_no, msg_data.slot_offset[CORE_ADDR_WIDTH-1:0]};
      tx_desc_len     <= msg_data.pkt_len;
      port_r          <= port;
      last_core[port] <= msg_core_no;
      last_slot[port] <= msg_data.slot_no[slot_no_width-1:0];
    end
  end

  assign tx_desc_valid[0] = valid_r && !port_r;
  assign tx_desc_valid[1] = valid_r && port_r;

  // Port 1 wins if both ports finish together
  assign recycle_valid = |pkt_sent_out_valid;
  assign recycle_desc  = pkt_sent_out_valid[1] ? {last_core[1], last_slot[1]} :
                                                 {last_core[0], last_slot[0]};

endmodule

// ==== slot_dma_top.sv ====
module slot_dma_top import slot_dma_pkg::*; #(
  parameter int CORE_COUNT      = 16,
  parameter int SLOT_COUNT      = 16,
  parameter int CORE_ADDR_WIDTH = 16
) (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              inject_valid,
  input  logic [$clog2(CORE_COUNT)+$clog2(SLOT_COUNT)-1:0]  inject_desc,
  output logic                                              inject_ready,
  input  logic                                              slot_addr_wr_valid,
  input  logic [$clog2(SLOT_COUNT)-1:0]                     slot_addr_wr_no,
  input  logic [CORE_ADDR_WIDTH-1-SLOT_LEAD_ZERO-1:0]       slot_addr_wr_data,
  input  logic                                              drop_list_valid,
  input  logic [CORE_COUNT-1:0]                             drop_list,
  input  logic                                              max_pkt_len_valid,
  input  pkt_len_t                                          max_pkt_len,
  input  logic [PORT_COUNT-1:0]                             incoming_pkt_ready,
  input  logic [PORT_COUNT-1:0]                             rx_desc_ready,
  output logic [PORT_COUNT-1:0]                             rx_desc_valid,
  output logic [CORE_ADDR_WIDTH+$clog2(CORE_COUNT)-1:0]     rx_desc_addr,
  output pkt_len_t                                          rx_desc_len,
  input  logic                                              msg_valid,
  input  core_msg_t                                         msg_data,
  input  logic [$clog2(CORE_COUNT)-1:0]                     msg_core_no,
  output logic                                              msg_ready,
  input  logic [PORT_COUNT-1:0]                             tx_desc_ready,
  output logic [PORT_COUNT-1:0]                             tx_desc_valid,
  output logic [CORE_ADDR_WIDTH+$clog2(CORE_COUNT)-1:0]     tx_desc_addr,
  output pkt_len_t                                          tx_desc_len,
  input  logic [PORT_COUNT-1:0]                             pkt_sent_out_valid
);

  localparam int core_no_width = $clog2(CORE_COUNT);
  localparam int slot_no_width = $clog2(SLOT_COUNT);
  localparam int addr_width    = CORE_ADDR_WIDTH + core_no_width;

  logic                                   recycle_valid;
  logic [core_no_width+slot_no_width-1:0] recycle_desc;
  logic                                   head_valid;
  logic [core_no_width+slot_no_width-1:0] head_desc;
  logic                                   head_pop;
  logic                                   cand_valid;
  logic [addr_width-1:0]                  cand_addr;
  logic                                   cand_take;
  pkt_len_t                               max_pkt_len_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      max_pkt_len_r <= DEFAULT_MAX_PKT_LEN;
    end else if (max_pkt_len_valid) begin
      max_pkt_len_r <= max_pkt_len;
    end
  end

  slot_queue #(
    .CORE_COUNT (CORE_COUNT),
    .SLOT_COUNT (SLOT_COUNT)
  ) u_slot_queue (
    .clk           (clk),
    .rst           (rst),
    .recycle_valid (recycle_valid),
    .recycle_desc  (recycle_desc),
    .inject_valid  (inject_valid),
    .inject_desc   (inject_desc),
    .inject_ready  (inject_ready),
    .head_valid    (head_valid),
    .head_desc     (head_desc),
    .head_pop      (head_pop)
  );

  // Candidate core and slot are left open, only the address goes on
  slot_addr_lookup #(
    .CORE_COUNT      (CORE_COUNT),
    .SLOT_COUNT      (SLOT_COUNT),
    .CORE_ADDR_WIDTH (CORE_ADDR_WIDTH)
  ) u_slot_addr_lookup (
    .clk                (clk),
    .rst                (rst),
    .head_valid         (head_valid),
    .head_desc          (head_desc),
    .head_pop           (head_pop),
    .slot_addr_wr_valid (slot_addr_wr_valid),
    .slot_addr_wr_no    (slot_addr_wr_no),
    .slot_addr_wr_data  (slot_addr_wr_data),
    .drop_list_valid    (drop_list_valid),
    .drop_list          (drop_list),
    .cand_valid         (cand_valid),
    .cand_core          (),
    .cand_slot          (),
    .cand_addr          (cand_addr),
    .cand_take          (cand_take)
  );

  rx_port_arbiter #(
    .CORE_COUNT      (CORE_COUNT),
    .CORE_ADDR_WIDTH (CORE_ADDR_WIDTH)
  ) u_rx_port_arbiter (
    .clk                (clk),
    .rst                (rst),
    .cand_valid         (cand_valid),
    .cand_addr          (cand_addr),
    .cand_take          (cand_take),
    .incoming_pkt_ready (incoming_pkt_ready),
    .rx_desc_ready      (rx_desc_ready),
    .max_pkt_len        (max_pkt_len_r),
    .rx_desc_valid      (rx_desc_valid),
    .rx_desc_addr       (rx_desc_addr),
    .rx_desc_len        (rx_desc_len)
  );

  tx_desc_issuer #(
    .CORE_COUNT      (CORE_COUNT),
    .SLOT_COUNT      (SLOT_COUNT),
    .CORE_ADDR_WIDTH (CORE_ADDR_WIDTH)
  ) u_tx_desc_issuer (
    .clk                (clk),
    .rst                (rst),
    .msg_valid          (msg_valid),
    .msg_data           (msg_data),
    .msg_core_no        (msg_core_no),
    .msg_ready          (msg_ready),
    .tx_desc_ready      (tx_desc_ready),
    .tx_desc_valid      (tx_desc_valid),
    .tx_desc_addr       (tx_desc_addr),
    .tx_desc_len        (tx_desc_len),
    .pkt_sent_out_valid (pkt_sent_out_valid),
    .recycle_valid      (recycle_valid),
    .recycle_desc       (recycle_desc)
  );

endmodule

// ==== tb_slot_dma.sv ====
module tb_slot_dma import slot_dma_pkg::*; ();

  localparam int CORE_COUNT      = 16;
  localparam int SLOT_COUNT      = 16;
  localparam int CORE_ADDR_WIDTH = 16;
  localparam int core_no_width   = $clog2(CORE_COUNT);
  localparam int slot_no_width   = $clog2(SLOT_COUNT);
  localparam int slot_addr_eff   = CORE_ADDR_WIDTH - 1 - SLOT_LEAD_ZERO;
  localparam int addr_width      = CORE_ADDR_WIDTH + core_no_width;
  localparam int desc_width      = core_no_width + slot_no_width;
  localparam int drain_limit     = 2000;

  logic                     clk;
  logic                     rst;
  logic                     inject_valid;
  logic [desc_width-1:0]    inject_desc;
  logic                     inject_ready;
  logic                     slot_addr_wr_valid;
  logic [slot_no_width-1:0] slot_addr_wr_no;
  logic [slot_addr_eff-1:0] slot_addr_wr_data;
  logic                     drop_list_valid;
  logic [CORE_COUNT-1:0]    drop_list;
  logic                     max_pkt_len_valid;
  pkt_len_t                 max_pkt_len;
  logic [1:0]               incoming_pkt_ready;
  logic [1:0]               rx_desc_ready;
  logic [1:0]               rx_desc_valid;
  logic [addr_width-1:0]    rx_desc_addr;
  pkt_len_t                 rx_desc_len;
  logic                     msg_valid;
  core_msg_t                msg_data;
  logic [core_no_width-1:0] msg_core_no;
  logic                     msg_ready;
  logic [1:0]               tx_desc_ready;
  logic [1:0]               tx_desc_valid;
  logic [addr_width-1:0]    tx_desc_addr;
  pkt_len_t                 tx_desc_len;
  logic [1:0]               pkt_sent_out_valid;

  // Reference model state
  logic [15:0]              lfsr;
  logic [desc_width-1:0]    exp_q [$];
  logic [slot_addr_eff-1:0] table_model [SLOT_COUNT];
  logic [CORE_COUNT-1:0]    drop_model;
  pkt_len_t                 max_len_model;
  logic [core_no_width-1:0] last_core [2];
  logic [slot_no_width-1:0] last_slot [2];
  logic [1:0]               has_last;
  int                       pend [2];
  int                       pulses [2];
  int                       served [2];
  logic                     last_served;
  logic                     tx_exp_valid;
  logic                     tx_exp_port;
  logic [addr_width-1:0]    tx_exp_addr;
  pkt_len_t                 tx_exp_len;
  int                       tx_count;
  int                       value_errors;
  int                       other_errors;
  logic [desc_width-1:0]    desc;
  logic [1:0]               qual;
  logic                     port;

  always #50 clk = ~clk;

  slot_dma_top u_dut (
    .clk                (clk),
    .rst                (rst),
    .inject_valid       (inject_valid),
    .inject_desc        (inject_desc),
    .inject_ready       (inject_ready),
    .slot_addr_wr_valid (slot_addr_wr_valid),
    .slot_addr_wr_no    (slot_addr_wr_no),
    .slot_addr_wr_data  (slot_addr_wr_data),
    .drop_list_valid    (drop_list_valid),
    .drop_list          (drop_list),
    .max_pkt_len_valid  (max_pkt_len_valid),
    .max_pkt_len        (max_pkt_len),
    .incoming_pkt_ready (incoming_pkt_ready),
    .rx_desc_ready      (rx_desc_ready),
    .rx_desc_valid      (rx_desc_valid),
    .rx_desc_addr       (rx_desc_addr),
    .rx_desc_len        (rx_desc_len),
    .msg_valid          (msg_valid),
    .msg_data           (msg_data),
    .msg_core_no        (msg_core_no),
    .msg_ready          (msg_ready),
    .tx_desc_ready      (tx_desc_ready),
    .tx_desc_valid      (tx_desc_valid),
    .tx_desc_addr       (tx_desc_addr),
    .tx_desc_len        (tx_desc_len),
    .pkt_sent_out_valid (pkt_sent_out_valid)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic check_rx_desc(input logic [addr_width-1:0] exp_addr, input pkt_len_t exp_len);
    if (rx_desc_addr !== exp_addr) begin
      value_errors++;
      $display("FAIL %0t rx_desc_addr expected %h actual %h", $time, exp_addr, rx_desc_addr);
    end
    if (rx_desc_len !== exp_len) begin
      value_errors++;
      $display("FAIL %0t rx_desc_len expected %0d actual %0d", $time, exp_len, rx_desc_len);
    end
  endtask

  task automatic check_tx_desc(input logic [addr_width-1:0] exp_addr, input pkt_len_t exp_len,
                               input logic exp_port);
    logic [1:0] exp_valid;
    exp_valid = exp_port ? 2'b10 : 2'b01;
    if (tx_desc_valid !== exp_valid) begin
      value_errors++;
      $display("FAIL %0t tx_desc_valid expected %b actual %b", $time, exp_valid, tx_desc_valid);
    end
    if (tx_desc_addr !== exp_addr) begin
      value_errors++;
      $display("FAIL %0t tx_desc_addr expected %h actual %h", $time, exp_addr, tx_desc_addr);
    end
    if (tx_desc_len !== exp_len) begin
      value_errors++;
      $display("FAIL %0t tx_desc_len expected %0d actual %0d", $time, exp_len, tx_desc_len);
    end
  endtask

  task automatic check_ready(input string name, input logic exp_ready, input logic act_ready);
    if (act_ready !== exp_ready) begin
      value_errors++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp_ready, act_ready);
    end
  endtask

  // Model update and checks on every rising edge
  always @(posedge clk) begin
    if (rst) begin
      exp_q.delete();
      drop_model    = '0;
      max_len_model = 16'd1024;
      pend[0]       = 0;
      pend[1]       = 0;
      last_served   = 1'b1;
      has_last      = '0;
      tx_exp_valid  = 1'b0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        qual[p] = rx_desc_ready[p] && (pend[p] != 0 || incoming_pkt_ready[p]);
      end
      if (rx_desc_valid == 2'b11) begin
        other_errors++;
        $display("%0t: receive descriptor issued on both ports at once", $time);
      end else if (rx_desc_valid != 2'b00) begin
        port = rx_desc_valid[1];
        if (!qual[port]) begin
          other_errors++;
          $display("%0t: port %0d served while not ready or with no packet", $time, port);
        end
        if (qual == 2'b11 && port == last_served) begin
          other_errors++;
          $display("%0t: port %0d served twice in a row while both waited", $time, port);
        end
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("%0t: receive descriptor issued with no slot expected", $time);
        end else begin
          desc = exp_q.pop_front();
          check_rx_desc({desc[desc_width-1:slot_no_width], 1'b0,
                         table_model[desc[slot_no_width-1:0]], 8'h0A}, max_len_model);
        end
        last_served = port;
        served[port]++;
      end
      for (int p = 0; p < 2; p++) begin
        if (incoming_pkt_ready[p]) begin
          pulses[p]++;
        end
        if (incoming_pkt_ready[p] && !rx_desc_valid[p]) begin
          pend[p]++;
        end else if (rx_desc_valid[p] && !incoming_pkt_ready[p]) begin
          pend[p]--;
        end
      end

      if (tx_exp_valid) begin
        check_tx_desc(tx_exp_addr, tx_exp_len, tx_exp_port);
        tx_count++;
      end else if (tx_desc_valid != 2'b00) begin
        other_errors++;
        $display("%0t: transmit descriptor without an accepted message", $time);
      end

      // Recycle goes in before the last descriptor of the port moves on
      if (pkt_sent_out_valid != 2'b00) begin
        port = pkt_sent_out_valid[1];
        check_ready("inject_ready", 1'b0, inject_ready);
        if (!drop_model[last_core[port]]) begin
          exp_q.push_back({last_core[port], last_slot[port]});
        end
      end else if (inject_valid && inject_ready) begin
        if (!drop_model[inject_desc[desc_width-1:slot_no_width]]) begin
          exp_q.push_back(inject_desc);
        end
      end

      // Ready needs the named port ready and no descriptor issued last cycle
      check_ready("msg_ready", tx_desc_ready[msg_data.out_port[0]] && !tx_exp_valid,
                  msg_ready);

      tx_exp_valid = msg_valid && msg_ready && (msg_data.pkt_len != '0);
      if (tx_exp_valid) begin
        tx_exp_port            = msg_data.out_port[0];
        tx_exp_addr            = {msg_core_no, msg_data.slot_offset};
        tx_exp_len             = msg_data.pkt_len;
        last_core[tx_exp_port] = msg_core_no;
        last_slot[tx_exp_port] = msg_data.slot_no[slot_no_width-1:0];
        has_last[tx_exp_port]  = 1'b1;
      end

      if (slot_addr_wr_valid) begin
        table_model[slot_addr_wr_no] = slot_addr_wr_data;
      end
      if (drop_list_valid) begin
        drop_model = drop_list;
      end
      if (max_pkt_len_valid) begin
        max_len_model = max_pkt_len;
      end
    end
  end

  task automatic write_slot_table();
    for (int s = 0; s < SLOT_COUNT; s++) begin
      slot_addr_wr_valid = 1'b1;
      slot_addr_wr_no    = slot_no_width'(s);
      slot_addr_wr_data  = slot_addr_eff'(lfsr_bits(slot_addr_eff));
      @(negedge clk);
    end
    slot_addr_wr_valid = 1'b0;
  endtask

  task automatic load_drop_list();
    drop_list_valid = 1'b1;
    drop_list       = CORE_COUNT'(lfsr_bits(CORE_COUNT));
    // Core 0 stays live so that draining can always supply a slot
    drop_list[0]    = 1'b0;
    @(negedge clk);
    drop_list_valid = 1'b0;
  endtask

  task automatic run_random_traffic(input int cycles);
    logic p;
    for (int i = 0; i < cycles; i++) begin
      inject_valid          = (lfsr_bits(2) == 0);
      inject_desc           = desc_width'(lfsr_bits(desc_width));
      incoming_pkt_ready[0] = (lfsr_bits(2) == 0);
      incoming_pkt_ready[1] = (lfsr_bits(2) == 0);
      rx_desc_ready[0]      = (lfsr_bits(2) != 0);
      rx_desc_ready[1]      = (lfsr_bits(2) != 0);
      tx_desc_ready         = 2'(lfsr_bits(2));
      msg_valid             = 1'(lfsr_bits(1));
      msg_core_no           = core_no_width'(lfsr_bits(core_no_width));
      msg_data.pkt_len      = (lfsr_bits(2) == 0) ? '0 : pkt_len_t'(lfsr_bits(LEN_WIDTH));
      msg_data.out_port     = 8'(lfsr_bits(8));
      msg_data.slot_no      = 8'(lfsr_bits(8));
      msg_data.slot_offset  = 16'(lfsr_bits(16));
      msg_data.reserved     = 16'(lfsr_bits(16));
      p                     = 1'(lfsr_bits(1));
      pkt_sent_out_valid    = '0;
      if (lfsr_bits(3) == 0 && has_last[p]) begin
        pkt_sent_out_valid[p] = 1'b1;
      end
      max_pkt_len_valid     = (lfsr_bits(6) == 0);
      max_pkt_len           = pkt_len_t'(lfsr_bits(LEN_WIDTH));
      @(negedge clk);
    end
  endtask

  task automatic drain_engine();
    int   n;
    logic p;
    n                  = 0;
    inject_valid       = 1'b0;
    msg_valid          = 1'b0;
    pkt_sent_out_valid = '0;
    max_pkt_len_valid  = 1'b0;
    rx_desc_ready      = 2'b11;
    while ((exp_q.size() != 0 || pend[0] != 0 || pend[1] != 0 || tx_exp_valid) &&
           n < drain_limit) begin
      // A packet for every queued slot, a slot for every waiting packet
      incoming_pkt_ready = '0;
      if (exp_q.size() > pend[0] + pend[1]) begin
        p = 1'(lfsr_bits(1));
        incoming_pkt_ready[p] = 1'b1;
      end
      inject_valid = (exp_q.size() == 0) && (pend[0] + pend[1] > 0);
      inject_desc  = {core_no_width'(0), slot_no_width'(lfsr_bits(slot_no_width))};
      @(negedge clk);
      n++;
    end
    incoming_pkt_ready = '0;
    inject_valid       = 1'b0;
    if (exp_q.size() != 0 || pend[0] != 0 || pend[1] != 0) begin
      other_errors++;
      $display("%0t: timeout, %0d slots still expected", $time, exp_q.size());
    end
    for (int q = 0; q < 2; q++) begin
      if (pulses[q] != served[q]) begin
        other_errors++;
        $display("Port %0d got %0d descriptors for %0d packets", q, served[q], pulses[q]);
      end
    end
  endtask

  initial begin
    clk                = 1'b0;
    rst                = 1'b1;
    lfsr               = 16'd18400;
    inject_valid       = 1'b0;
    inject_desc        = '0;
    slot_addr_wr_valid = 1'b0;
    slot_addr_wr_no    = '0;
    slot_addr_wr_data  = '0;
    drop_list_valid    = 1'b0;
    drop_list          = '0;
    max_pkt_len_valid  = 1'b0;
    max_pkt_len        = '0;
    incoming_pkt_ready = '0;
    rx_desc_ready      = '0;
    msg_valid          = 1'b0;
    msg_data           = '0;
    msg_core_no        = '0;
    tx_desc_ready      = '0;
    pkt_sent_out_valid = '0;
    value_errors       = 0;
    other_errors       = 0;
    tx_count           = 0;
    for (int p = 0; p < 2; p++) begin
      pulses[p] = 0;
      served[p] = 0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    write_slot_table();
    run_random_traffic(400);
    drain_engine();

    // Second round with a new table and some cores dropped
    write_slot_table();
    load_drop_list();
    run_random_traffic(400);
    drain_engine();

    if (served[0] + served[1] == 0 || tx_count == 0) begin
      other_errors++;
      $display("No receive or no transmit descriptor was seen");
    end
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== slot_dma.f ====
slot_dma_pkg.sv
slot_queue.sv
slot_addr_lookup.sv
rx_port_arbiter.sv
tx_desc_issuer.sv
slot_dma_top.sv
tb_slot_dma.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_slot_dma
FILELIST  ?= slot_dma.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
